// File: rtl/videoPkg.sv
package videoPkg;

    // --------------------
    // Display geometry
    // --------------------
    // Horizontal, in pixel clocks
    localparam int hDisplay = 16;
    localparam int hBack    = 4;
    localparam int hFront   = 2;
    localparam int hSync    = 3;
    localparam int hTotal   = hDisplay + hFront + hSync + hBack;

    // Vertical, in lines
    localparam int vDisplay = 6;
    localparam int vTop     = 2;
    localparam int vBottom  = 1;
    localparam int vSync    = 2;
    localparam int vTotal   = vDisplay + vBottom + vSync + vTop;

    // Sync windows, active video first then front porch
    localparam int hSyncStart = hDisplay + hFront;
    localparam int hSyncEnd   = hSyncStart + hSync;
    localparam int vSyncStart = vDisplay + vBottom;
    localparam int vSyncEnd   = vSyncStart + vSync;

    // Counter widths
    localparam int hCountWidth = $clog2(hTotal);
    localparam int vCountWidth = $clog2(vTotal);
    localparam int xWidth      = $clog2(hDisplay);
    localparam int yWidth      = $clog2(vDisplay);

    // --------------------
    // Line buffer
    // --------------------
    // Depth doubles as the starting credit count
    localparam int buffDepth   = 8;
    localparam int ptrWidth    = $clog2(buffDepth);
    localparam int creditWidth = $clog2(buffDepth + 1);

    // Backlight PWM period is 2**pwmWidth cycles
    localparam int pwmWidth = 4;

    // --------------------
    // Types
    // --------------------
    // 4:4:4 colour
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgbPixelT;

    // Syncs are active low
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
        logic lineEnd;
        logic frameEnd;
    } videoTimingT;

    typedef enum logic [1:0] {
        patSolid,
        patBars,
        patGradient,
        patChecker
    } patternOpT;

    // Registered panel pins
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
        logic       hsync;
        logic       vsync;
        logic       de;
    } tftPortT;

    // Blanking values, syncs inactive
    localparam rgbPixelT blackPixel = '{red: 4'h0, green: 4'h0, blue: 4'h0};
    localparam rgbPixelT whitePixel = '{red: 4'hF, green: 4'hF, blue: 4'hF};
    localparam videoTimingT timingIdle = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0,
                                          lineEnd: 1'b0, frameEnd: 1'b0};
    localparam tftPortT tftIdle = '{red: 4'h0, green: 4'h0, blue: 4'h0,
                                   hsync: 1'b1, vsync: 1'b1, de: 1'b0};

endpackage

// File: rtl/displayTiming.sv
`timescale 1ns/10ps

module displayTiming
(
    input  logic                  pixelClk,
    input  logic                  reset,
    output videoPkg::videoTimingT timing
);

    import videoPkg::*;

    // --------------------
    // Raster counters
    // --------------------
    logic [hCountWidth-1:0] hCount;
    logic [vCountWidth-1:0] vCount;
    logic                   hLast;
    logic                   vLast;

    // Region decodes
    logic hActive;
    logic vActive;
    logic hSyncZone;
    logic vSyncZone;

    // Last pixel of a line, last line of a frame
    assign hLast = (hCount == hCountWidth'(hTotal - 1));
    assign vLast = (vCount == vCountWidth'(vTotal - 1));

    // Horizontal walk and vertical step at end of line
    always_ff @(posedge pixelClk)
    begin
        if (reset)
        begin
            // Parked on the last pixel of a frame, wraps to 0 on release
            hCount <= hCountWidth'(hTotal - 1);
            vCount <= vCountWidth'(vTotal - 1);
        end
        else if (hLast)
        begin
            hCount <= '0;
            if (vLast)
            begin
                vCount <= '0;
            end
            else
            begin
                vCount <= vCount + 1'b1;
            end
        end
        else
        begin
            hCount <= hCount + 1'b1;
        end
    end

    // --------------------
    // Region decode
    // --------------------
    // Active video at start of line and frame
    assign hActive   = (hCount < hCountWidth'(hDisplay));
    assign vActive   = (vCount < vCountWidth'(vDisplay));
    // Sync after front porch
    assign hSyncZone = (hCount >= hCountWidth'(hSyncStart))
                    && (hCount < hCountWidth'(hSyncEnd));
    assign vSyncZone = (vCount >= vCountWidth'(vSyncStart))
                    && (vCount < vCountWidth'(vSyncEnd));

    // Timing struct, one register stage behind the counters
    always_ff @(posedge pixelClk)
    begin
        if (reset)
        begin
            timing <= timingIdle;
        end
        else
        begin
            timing.hsync    <= ~hSyncZone;
            timing.vsync    <= ~vSyncZone;
            timing.de       <= hActive && vActive;
            timing.lineEnd  <= hLast;
            timing.frameEnd <= hLast && vLast;
        end
    end

endmodule

// File: rtl/pixelSource.sv
`timescale 1ns/10ps

module pixelSource
(
    input  logic                pixelClk,
    input  logic                reset,
    input  videoPkg::patternOpT pattern,
    input  videoPkg::rgbPixelT  solidColor,
    input  logic                creditReturn,
    output logic                pushValid,
    output videoPkg::rgbPixelT  pushPixel
);

    import videoPkg::*;

    // --------------------
    // State
    // --------------------
    // Free buffer slots
    logic [creditWidth-1:0] credits;
    logic                   canPush;

    // Raster position of the next pixel
    logic [xWidth-1:0] xPos;
    logic [yWidth-1:0] yPos;
    logic              frameStart;

    // Pattern held for the whole frame
    patternOpT frameOp;
    rgbPixelT  frameColor;
    patternOpT activeOp;
    rgbPixelT  activeColor;

    // Colour rules for one pixel
    function automatic rgbPixelT drawPixel(
        input patternOpT         op,
        input rgbPixelT          color,
        input logic [xWidth-1:0] x,
        input logic [yWidth-1:0] y
    );
        rgbPixelT   pix;
        logic [2:0] bar;
        pix = blackPixel;
        // Bars are 2 pixels wide
        bar = 3'(x >> 1);
        case (op)
            patSolid:
            begin
                pix = color;
            end
            patBars:
            begin
                pix.red   = {4{bar[2]}};
                pix.green = {4{bar[1]}};
                pix.blue  = {4{bar[0]}};
            end
            patGradient:
            begin
                pix.red   = 4'(x);
                pix.green = 4'(y);
                pix.blue  = 4'(x) ^ 4'(y);
            end
            patChecker:
            begin
                // 2x2 squares
                pix = (x[1] ^ y[1]) ? whitePixel : blackPixel;
            end
            default:
            begin
                pix = blackPixel;
            end
        endcase
        return pix;
    endfunction

    assign canPush    = (credits != '0);
    assign frameStart = (xPos == '0) && (yPos == '0);

    // Pixel (0,0) takes the live inputs, the rest the latched copy
    assign activeOp    = frameStart ? pattern : frameOp;
    assign activeColor = frameStart ? solidColor : frameColor;

    // --------------------
    // Credit loop
    // --------------------
    // One credit per push, one back per return
    always_ff @(posedge pixelClk)
    begin
        if (reset)
        begin
            credits <= creditWidth'(buffDepth);
        end
        else
        begin
            credits <= credits - creditWidth'(canPush) + creditWidth'(creditReturn);
        end
    end

    // Position advances only on a push, held while stalled
    always_ff @(posedge pixelClk)
    begin
        if (reset)
        begin
            pushValid <= 1'b0;
            xPos      <= '0;
            yPos      <= '0;
        end
        else
        begin
            pushValid <= canPush;
            if (canPush)
            begin
                if (xPos == xWidth'(hDisplay - 1))
                begin
                    xPos <= '0;
                    yPos <= (yPos == yWidth'(vDisplay - 1)) ? '0 : yPos + 1'b1;
                end
                else
                begin
                    xPos <= xPos + 1'b1;
                end
            end
        end
    end

    // Pixel data and frame latch
    always_ff @(posedge pixelClk)
    begin
        if (canPush)
        begin
            pushPixel <= drawPixel(activeOp, activeColor, xPos, yPos);
            if (frameStart)
            begin
                frameOp    <= pattern;
                frameColor <= solidColor;
            end
        end
    end

endmodule

// File: rtl/pixelBuffer.sv
`timescale 1ns/10ps

module pixelBuffer
(
    input  logic               pixelClk,
    input  logic               reset,
    input  logic               pushValid,
    input  videoPkg::rgbPixelT pushPixel,
    input  logic               pop,
    output videoPkg::rgbPixelT headPixel,
    output logic               empty
);

    import videoPkg::*;

    // --------------------
    // Storage
    // --------------------
    rgbPixelT store [buffDepth];

    logic [ptrWidth-1:0]    wrPtr;
    logic [ptrWidth-1:0]    rdPtr;
    // Occupancy, 0 to buffDepth
    logic [creditWidth-1:0] count;
    logic                   doPop;

    // Circular pointer step
    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        logic [ptrWidth-1:0] step;
        step = (ptr == ptrWidth'(buffDepth - 1)) ? '0 : ptr + 1'b1;
        return step;
    endfunction

    // Oldest word always on the head
    assign headPixel = store[rdPtr];
    assign empty     = (count == '0);
    // Ignore a pop on an empty buffer
    assign doPop     = pop && !empty;

    // Write side
    always_ff @(posedge pixelClk)
    begin
        if (pushValid)
        begin
            store[wrPtr] <= pushPixel;
        end
    end

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge pixelClk)
    begin
        if (reset)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (pushValid)
            begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop)
            begin
                rdPtr <= nextPtr(rdPtr);
            end
            // Simultaneous push and pop leave count as is
            count <= count + creditWidth'(pushValid) - creditWidth'(doPop);
        end
    end

endmodule

// File: rtl/tftOutput.sv
`timescale 1ns/10ps

module tftOutput
(
    input  logic                    pixelClk,
    input  logic                    reset,
    input  videoPkg::videoTimingT   timing,
    input  videoPkg::rgbPixelT      headPixel,
    input  logic                    empty,
    input  logic [videoPkg::pwmWidth-1:0] backLightDuty,
    output logic                    pop,
    output logic                    creditReturn,
    output videoPkg::tftPortT       tft,
    output logic                    backLight,
    output logic                    underflow
);

    import videoPkg::*;

    // Pixel sent to the panel this cycle
    rgbPixelT pixelOut;
    // Active video with nothing buffered
    logic     starved;

    // Backlight PWM phase
    logic [pwmWidth-1:0] pwmCount;

    // --------------------
    // Pixel path
    // --------------------
    // Take one pixel per active cycle
    assign pop      = timing.de && !empty;
    assign starved  = timing.de && empty;
    // Black during blanking and on a starved cycle
    assign pixelOut = pop ? headPixel : blackPixel;

    // Panel pins, one cycle after the timing
    always_ff @(posedge pixelClk)
    begin
        if (reset)
        begin
            tft <= tftIdle;
        end
        else
        begin
            tft.red   <= pixelOut.red;
            tft.green <= pixelOut.green;
            tft.blue  <= pixelOut.blue;
            tft.hsync <= timing.hsync;
            tft.vsync <= timing.vsync;
            tft.de    <= timing.de;
        end
    end

    // Credit back to the source, pop one cycle late
    // Sticky underflow flag
    always_ff @(posedge pixelClk)
    begin
        if (reset)
        begin
            creditReturn <= 1'b0;
            underflow    <= 1'b0;
        end
        else
        begin
            creditReturn <= pop;
            if (starved)
            begin
                underflow <= 1'b1;
            end
        end
    end

    // --------------------
    // Backlight PWM
    // --------------------
    // Free-running, high for backLightDuty of every 16 cycles
    always_ff @(posedge pixelClk)
    begin
        if (reset)
        begin
            pwmCount  <= '0;
            backLight <= 1'b0;
        end
        else
        begin
            pwmCount  <= pwmCount + 1'b1;
            backLight <= (pwmCount < backLightDuty);
        end
    end

endmodule

// File: rtl/tftVideoSystem.sv
`timescale 1ns/10ps

module tftVideoSystem
(
    input  logic                          pixelClk,
    input  logic                          reset,
    input  videoPkg::patternOpT           pattern,
    input  videoPkg::rgbPixelT            solidColor,
    input  logic [videoPkg::pwmWidth-1:0] backLightDuty,
    output videoPkg::tftPortT             tft,
    output logic                          backLight,
    output logic                          underflow
);

    import videoPkg::*;

    // --------------------
    // Stage wiring
    // --------------------
    // Timing to output stage
    videoTimingT timing;

    // Source to buffer
    logic     pushValid;
    rgbPixelT pushPixel;

    // Buffer to output stage and back
    rgbPixelT headPixel;
    logic     empty;
    logic     pop;
    logic     creditReturn;

    // Raster timing
    displayTiming i_displayTiming
    (
        .pixelClk     (pixelClk),
        .reset        (reset),
        .timing       (timing)
    );

    // Pattern drawing, runs ahead on credits
    pixelSource i_pixelSource
    (
        .pixelClk     (pixelClk),
        .reset        (reset),
        .pattern      (pattern),
        .solidColor   (solidColor),
        .creditReturn (creditReturn),
        .pushValid    (pushValid),
        .pushPixel    (pushPixel)
    );

    // Line buffer between source and panel
    pixelBuffer i_pixelBuffer
    (
        .pixelClk     (pixelClk),
        .reset        (reset),
        .pushValid    (pushValid),
        .pushPixel    (pushPixel),
        .pop          (pop),
        .headPixel    (headPixel),
        .empty        (empty)
    );

    // Merge pixels with timing, drive the panel
    tftOutput i_tftOutput
    (
        .pixelClk      (pixelClk),
        .reset         (reset),
        .timing        (timing),
        .headPixel     (headPixel),
        .empty         (empty),
        .backLightDuty (backLightDuty),
        .pop           (pop),
        .creditReturn  (creditReturn),
        .tft           (tft),
        .backLight     (backLight),
        .underflow     (underflow)
    );

endmodule

// File: tb/tbTftVideoSystem.sv
`timescale 1ns/10ps

module tbTftVideoSystem;

    import videoPkg::*;

    // --------------------
    // Run length
    // --------------------
    localparam int numRows      = 6;
    localparam int framesPerRow = 3;
    localparam int frameCycles  = hTotal * vTotal;
    // Lead-in frame plus three per row, with spare frames
    localparam int cycleLimit   = (numRows * framesPerRow + 4) * frameCycles;

    // DUT ports
    logic                pixelClk;
    logic                reset;
    patternOpT           pattern;
    rgbPixelT            solidColor;
    logic [pwmWidth-1:0] backLightDuty;
    tftPortT             tft;
    logic                backLight;
    logic                underflow;

    // Stimulus table, one row per pattern setting
    string               rowName  [numRows];
    patternOpT           rowOp    [numRows];
    rgbPixelT            rowColor [numRows];
    logic [pwmWidth-1:0] rowDuty  [numRows];

    // Raster model, rebuilt from the panel pins
    int   cycleCount;
    int   xPos;
    int   yPos;
    int   hsyncLow;
    int   vsyncLow;
    int   lastFall;
    int   framesSeen;
    logic prevDe;
    logic prevHsync;
    logic prevVsync;
    logic vsyncFell;

    // Checking window and backlight history
    logic        checkOn;
    int          checkRow;
    logic [15:0] blHistory;
    int          blSamples;

    tftVideoSystem i_tftVideoSystem
    (
        .pixelClk      (pixelClk),
        .reset         (reset),
        .pattern       (pattern),
        .solidColor    (solidColor),
        .backLightDuty (backLightDuty),
        .tft           (tft),
        .backLight     (backLight),
        .underflow     (underflow)
    );

    always #5 pixelClk = ~pixelClk;

    // --------------------
    // Error handling
    // --------------------
    task automatic failRun(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkPixel(input string name, input rgbPixelT exp, input rgbPixelT act);
        if (exp !== act)
        begin
            failRun($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic checkTiming(input string name, input tftPortT exp, input tftPortT act);
        if (exp !== act)
        begin
            failRun($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            failRun($sformatf("mismatch %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic checkCount(input string name, input int exp, input int act);
        if (exp != act)
        begin
            failRun($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    // --------------------
    // Reference colours
    // --------------------
    function automatic rgbPixelT expectedPixel(input patternOpT op, input rgbPixelT color,
                                               input int col, input int row);
        rgbPixelT pix;
        int       bar;
        bar = col / 2;
        pix = blackPixel;
        case (op)
            patSolid:
            begin
                pix = color;
            end
            patBars:
            begin
                // Index bits pick the primaries
                pix.red   = bar[2] ? 4'hF : 4'h0;
                pix.green = bar[1] ? 4'hF : 4'h0;
                pix.blue  = bar[0] ? 4'hF : 4'h0;
            end
            patGradient:
            begin
                pix.red   = 4'(col);
                pix.green = 4'(row);
                pix.blue  = 4'(col ^ row);
            end
            patChecker:
            begin
                if (((col >> 1) & 1) != ((row >> 1) & 1))
                begin
                    pix = whitePixel;
                end
            end
            default:
            begin
                pix = blackPixel;
            end
        endcase
        return pix;
    endfunction

    // Solid rows get random colours, duties cover both ends
    task automatic fillTable();
        rowName[0] = "solidA";
        rowOp[0]   = patSolid;
        rowName[1] = "bars";
        rowOp[1]   = patBars;
        rowName[2] = "gradient";
        rowOp[2]   = patGradient;
        rowName[3] = "checker";
        rowOp[3]   = patChecker;
        rowName[4] = "solidB";
        rowOp[4]   = patSolid;
        rowName[5] = "solidC";
        rowOp[5]   = patSolid;
        for (int i = 0; i < numRows; i++)
        begin
            rowColor[i] = 12'($urandom());
            rowDuty[i]  = 4'($urandom());
        end
        rowDuty[1] = 4'h0;
        rowDuty[3] = 4'hF;
    endtask

    task automatic checkResetState(input string name);
        checkTiming(name, tftIdle, tft);
        checkFlag({name, " backLight"}, 1'b0, backLight);
        checkFlag({name, " underflow"}, 1'b0, underflow);
    endtask

    // --------------------
    // One clock of checking
    // --------------------
    task automatic stepCycle();
        rgbPixelT actPix;
        rgbPixelT expPix;
        @(negedge pixelClk);
        cycleCount++;
        if (cycleCount > cycleLimit)
        begin
            failRun("timeout: the test sequence did not finish within the cycle limit");
        end
        actPix.red   = tft.red;
        actPix.green = tft.green;
        actPix.blue  = tft.blue;
        vsyncFell    = prevVsync && !tft.vsync;
        checkFlag("underflow", 1'b0, underflow);

        // Active pixel against the model, black in blanking
        if (tft.de)
        begin
            if (checkOn)
            begin
                expPix = expectedPixel(rowOp[checkRow], rowColor[checkRow], xPos, yPos);
                checkPixel(rowName[checkRow], expPix, actPix);
            end
            xPos++;
        end
        else
        begin
            checkPixel("blanking", blackPixel, actPix);
            if (prevDe)
            begin
                checkCount("active pixels per line", hDisplay, xPos);
                xPos = 0;
                yPos++;
            end
        end

        // Sync pulse widths, checked as each pulse ends
        if (!tft.hsync)
        begin
            hsyncLow++;
        end
        else if (!prevHsync)
        begin
            checkCount("hsync width", hSync, hsyncLow);
            hsyncLow = 0;
        end
        if (!tft.vsync)
        begin
            vsyncLow++;
        end
        else if (!prevVsync)
        begin
            checkCount("vsync width", vSync * hTotal, vsyncLow);
            vsyncLow = 0;
        end

        // Frame boundary
        if (vsyncFell)
        begin
            if (framesSeen > 0)
            begin
                checkCount("frame period", frameCycles, cycleCount - lastFall);
            end
            checkCount("active lines per frame", vDisplay, yPos);
            yPos       = 0;
            lastFall   = cycleCount;
            framesSeen++;
        end

        // Sliding 16-cycle backlight window
        if (checkOn)
        begin
            blHistory = {blHistory[14:0], backLight};
            blSamples++;
            if (blSamples >= 16)
            begin
                checkCount({rowName[checkRow], " backlight"}, int'(rowDuty[checkRow]),
                           $countones(blHistory));
            end
        end

        prevDe    = tft.de;
        prevHsync = tft.hsync;
        prevVsync = tft.vsync;
    endtask

    task automatic waitVsyncFall();
        do
        begin
            stepCycle();
        end
        while (!vsyncFell);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial
    begin
        pixelClk      = 1'b0;
        reset         = 1'b1;
        pattern       = patSolid;
        solidColor    = blackPixel;
        backLightDuty = '0;
        cycleCount    = 0;
        xPos          = 0;
        yPos          = 0;
        hsyncLow      = 0;
        vsyncLow      = 0;
        lastFall      = 0;
        framesSeen    = 0;
        prevDe        = 1'b0;
        prevHsync     = 1'b1;
        prevVsync     = 1'b1;
        vsyncFell     = 1'b0;
        checkOn       = 1'b0;
        checkRow      = 0;
        blHistory     = '0;
        blSamples     = 0;
        void'($urandom(61459));
        fillTable();

        // Reset for 4 cycles, then one more idle cycle
        repeat (4)
        begin
            @(negedge pixelClk);
            checkResetState("reset");
        end
        reset = 1'b0;
        @(negedge pixelClk);
        checkResetState("after reset");

        // Rows change during vsync, last two frames of each checked
        waitVsyncFall();
        for (int r = 0; r < numRows; r++)
        begin
            pattern       = rowOp[r];
            solidColor    = rowColor[r];
            backLightDuty = rowDuty[r];
            waitVsyncFall();
            checkRow  = r;
            checkOn   = 1'b1;
            blSamples = 0;
            waitVsyncFall();
            waitVsyncFall();
            checkOn = 1'b0;
        end

        checkFlag("final underflow", 1'b0, underflow);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: sim.f
rtl/videoPkg.sv
rtl/displayTiming.sv
rtl/pixelSource.sv
rtl/pixelBuffer.sv
rtl/tftOutput.sv
rtl/tftVideoSystem.sv
tb/tbTftVideoSystem.sv

// File: Makefile
# Verilator build and run of the video subsystem testbench

sim:
	verilator --binary --timing --top-module tbTftVideoSystem -f sim.f --Mdir obj_dir -o simv
	./obj_dir/simv

clean:
	rm -rf obj_dir

.PHONY: sim clean
